//--- src/MmuTypes.sv
package MmuTypes;

    // Sv32 address fields
    localparam int VpnWidth = 20;
    localparam int PpnWidth = 22;
    localparam int PaddrWidth = 34;
    localparam int PageOffsetWidth = 12;

    // Memory line geometry, four 32-bit entries per line
    localparam int LineWidth = 128;
    localparam int EntryIndexWidth = 2;
    localparam int MemAddrWidth = 30;

    // 16-entry direct-mapped TLB
    localparam int TlbIndexWidth = 4;

    typedef struct packed {
        logic [9:0] vpn1;
        logic [9:0] vpn0;
    } VirtualPageNumber;

    typedef struct packed {
        logic [11:0] ppn1;
        logic [9:0] ppn0;
    } PhysicalPageNumber;

    // Sv32 PTE, MSB first
    typedef struct packed {
        logic [11:0] ppn1;
        logic [9:0] ppn0;
        logic [1:0] reserved;
        logic dirty;
        logic accessed;
        logic global;
        logic user;
        logic execute;
        logic write;
        logic read;
        logic valid;
    } PageTableEntry;

    typedef struct packed {
        logic dirty;
        logic user;
        logic execute;
        logic write;
        logic read;
    } TlbEntryFlags;

    // A fault entry caches a failed walk
    typedef struct packed {
        logic valid;
        logic fault;
        PhysicalPageNumber pageNumber;
        TlbEntryFlags flags;
    } TlbEntry;

    typedef enum logic [1:0] {
        AccessInstruction = 2'd0,
        AccessLoad = 2'd1,
        AccessStore = 2'd2
    } MemoryAccessType;

    // Raw view for the memory port, entry view for picking one PTE
    typedef union packed {
        logic [LineWidth-1:0] raw;
        PageTableEntry [2**EntryIndexWidth-1:0] entries;
    } PageTableLine;

endpackage

//--- src/Tlb.sv
module Tlb (
    input  logic clk,
    input  logic rst,
    input  logic flush,
    input  MmuTypes::VirtualPageNumber lookupPage,
    output logic lookupHit,
    output MmuTypes::TlbEntry lookupEntry,
    input  logic writeEnable,
    input  MmuTypes::VirtualPageNumber writeKey,
    input  MmuTypes::TlbEntry writeValue
);
    import MmuTypes::*;

    logic [VpnWidth-1:0] lookupBits;
    logic [VpnWidth-1:0] writeBits;
    logic [TlbIndexWidth-1:0] lookupIndex;
    logic [TlbIndexWidth-1:0] writeIndex;
    logic [VpnWidth-TlbIndexWidth-1:0] lookupTag;
    logic [VpnWidth-TlbIndexWidth-1:0] writeTag;

    // Valid bits live apart from the payload so flush can clear them at once
    logic [2**TlbIndexWidth-1:0] validBits;
    logic [VpnWidth-TlbIndexWidth-1:0] tags [2**TlbIndexWidth];
    TlbEntry entries [2**TlbIndexWidth];

    always_comb begin
        lookupBits = lookupPage;
        writeBits = writeKey;
        lookupIndex = lookupBits[TlbIndexWidth-1:0];
        lookupTag = lookupBits[VpnWidth-1:TlbIndexWidth];
        writeIndex = writeBits[TlbIndexWidth-1:0];
        writeTag = writeBits[VpnWidth-1:TlbIndexWidth];
    end

    // Combinational lookup
    always_comb begin
        lookupEntry = entries[lookupIndex];
        lookupHit = validBits[lookupIndex] && (tags[lookupIndex] == lookupTag);
    end

    // A fill in the same cycle as a flush survives it
    always_ff @(posedge clk) begin
        if (rst) begin
            validBits <= '0;
        end else begin
            if (flush) begin
                validBits <= '0;
            end
            if (writeEnable) begin
                validBits[writeIndex] <= writeValue.valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            tags[writeIndex] <= writeTag;
            entries[writeIndex] <= writeValue;
        end
    end

endmodule

//--- src/TlbReplacer.sv
module TlbReplacer (
    input  logic clk,
    input  logic rst,
    input  logic enable,
    input  MmuTypes::VirtualPageNumber missPage,
    input  MmuTypes::MemoryAccessType missAccessType,
    input  logic [MmuTypes::PpnWidth-1:0] satpPpn,
    output logic done,
    output logic tlbWriteEnable,
    output MmuTypes::VirtualPageNumber tlbWriteKey,
    output MmuTypes::TlbEntry tlbWriteValue,
    output logic [MmuTypes::MemAddrWidth-1:0] memAddr,
    output logic memReadEnable,
    output logic memWriteEnable,
    output logic [MmuTypes::LineWidth-1:0] memWriteValue,
    input  logic memReadDone,
    input  logic memWriteDone,
    input  logic [MmuTypes::LineWidth-1:0] memReadValue
);
    import MmuTypes::*;

    typedef enum logic [3:0] {
        StateIdle = 4'h0,
        StateRead1 = 4'h1,
        StateDecode1 = 4'h2,
        StateWrite1 = 4'h3,
        StateRead0 = 4'h4,
        StateDecode0 = 4'h5,
        StateWrite0 = 4'h6,
        StateTlbWrite = 4'h7,
        StateTlbFault = 4'h8
    } State;

    function automatic logic isLeaf(PageTableEntry entry);
        return entry.read || entry.execute;
    endfunction

    // Invalid, or the reserved write-only encoding
    function automatic logic isFault(PageTableEntry entry);
        return !entry.valid || (entry.write && !entry.read);
    endfunction

    function automatic PageTableEntry markAccess(PageTableEntry entry,
                                                 MemoryAccessType accessType);
        PageTableEntry result;
        result = entry;
        result.accessed = 1'b1;
        // Dirty only for a store the page permits; other stores fault anyway
        if (accessType == AccessStore && entry.write) begin
            result.dirty = 1'b1;
        end
        return result;
    endfunction

    function automatic TlbEntryFlags toFlags(PageTableEntry entry);
        TlbEntryFlags result;
        result.dirty = entry.dirty;
        result.user = entry.user;
        result.execute = entry.execute;
        result.write = entry.write;
        result.read = entry.read;
        return result;
    endfunction

    State state;
    State nextState;

    // Walk context, captured when the walk starts
    MemoryAccessType accessType;
    VirtualPageNumber page;
    logic [PpnWidth-1:0] rootPpn;

    PageTableEntry entry1;
    PageTableEntry entry0;
    PageTableLine line;
    PhysicalPageNumber ppn;
    TlbEntryFlags flags;

    PageTableLine readLine;
    PageTableLine writeLine;
    PageTableEntry updated1;
    PageTableEntry updated0;
    logic [PaddrWidth-1:0] entryAddr1;
    logic [PaddrWidth-1:0] entryAddr0;
    logic [EntryIndexWidth-1:0] index1;
    logic [EntryIndexWidth-1:0] index0;
    logic inLevel1;

    always_comb begin
        entryAddr1 = {rootPpn, page.vpn1, 2'b00};
        entryAddr0 = {entry1.ppn1, entry1.ppn0, page.vpn0, 2'b00};
        index1 = entryAddr1[EntryIndexWidth+1:2];
        index0 = entryAddr0[EntryIndexWidth+1:2];
        readLine.raw = memReadValue;
        updated1 = markAccess(entry1, accessType);
        updated0 = markAccess(entry0, accessType);
    end

    always_comb begin
        nextState = state;
        case (state)
            StateIdle: if (enable) nextState = StateRead1;
            StateRead1: if (memReadDone) nextState = StateDecode1;
            StateDecode1: begin
                if (isFault(entry1)) begin
                    nextState = StateTlbFault;
                end else if (isLeaf(entry1)) begin
                    nextState = StateWrite1;
                end else begin
                    nextState = StateRead0;
                end
            end
            StateWrite1: if (memWriteDone) nextState = StateTlbWrite;
            StateRead0: if (memReadDone) nextState = StateDecode0;
            StateDecode0: begin
                // Level 0 must hold a leaf
                if (isFault(entry0) || !isLeaf(entry0)) begin
                    nextState = StateTlbFault;
                end else begin
                    nextState = StateWrite0;
                end
            end
            StateWrite0: if (memWriteDone) nextState = StateTlbWrite;
            default: nextState = StateIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= StateIdle;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge clk) begin
        if (state == StateIdle && enable) begin
            page <= missPage;
            accessType <= missAccessType;
            rootPpn <= satpPpn;
        end
        if (state == StateRead1 && memReadDone) begin
            line <= readLine;
            entry1 <= readLine.entries[index1];
        end
        if (state == StateRead0 && memReadDone) begin
            line <= readLine;
            entry0 <= readLine.entries[index0];
        end
        // Megapage takes ppn0 from the virtual address
        if (state == StateDecode1) begin
            ppn <= {entry1.ppn1, page.vpn0};
            flags <= toFlags(updated1);
        end
        if (state == StateDecode0) begin
            ppn <= {entry0.ppn1, entry0.ppn0};
            flags <= toFlags(updated0);
        end
    end

    // Memory port, address held for the whole access
    always_comb begin
        inLevel1 = state inside {StateRead1, StateDecode1, StateWrite1};
        memAddr = inLevel1 ? entryAddr1[PaddrWidth-1 -: MemAddrWidth]
                           : entryAddr0[PaddrWidth-1 -: MemAddrWidth];
        memReadEnable = (state == StateRead1) || (state == StateRead0);
        memWriteEnable = (state == StateWrite1) || (state == StateWrite0);

        writeLine = line;
        if (state == StateWrite1) begin
            writeLine.entries[index1] = updated1;
        end else begin
            writeLine.entries[index0] = updated0;
        end
        memWriteValue = writeLine.raw;
    end

    // TLB fill and completion share a cycle
    always_comb begin
        tlbWriteEnable = (state == StateTlbWrite) || (state == StateTlbFault);
        done = tlbWriteEnable;
        tlbWriteKey = page;
        tlbWriteValue.valid = 1'b1;
        if (state == StateTlbFault) begin
            tlbWriteValue.fault = 1'b1;
            tlbWriteValue.pageNumber = '0;
            tlbWriteValue.flags = '0;
        end else begin
            tlbWriteValue.fault = 1'b0;
            tlbWriteValue.pageNumber = ppn;
            tlbWriteValue.flags = flags;
        end
    end

endmodule

//--- src/Mmu.sv
module Mmu (
    input  logic clk,
    input  logic rst,
    input  logic reqValid,
    output logic reqReady,
    input  logic [31:0] reqAddr,
    input  MmuTypes::MemoryAccessType reqAccessType,
    output logic respValid,
    input  logic respReady,
    output logic [MmuTypes::PaddrWidth-1:0] respAddr,
    output logic respFault,
    input  logic [MmuTypes::PpnWidth-1:0] satpPpn,
    input  logic flush,
    output logic [MmuTypes::MemAddrWidth-1:0] memAddr,
    output logic memReadEnable,
    output logic memWriteEnable,
    output logic [MmuTypes::LineWidth-1:0] memWriteValue,
    input  logic memReadDone,
    input  logic memWriteDone,
    input  logic [MmuTypes::LineWidth-1:0] memReadValue
);
    import MmuTypes::*;

    typedef enum logic [1:0] {
        StateIdle,
        StateLookup,
        StateWalk
    } State;

    State state;
    // Lookup takes two cycles: TLB read, then permission check
    logic lookupStage;

    VirtualPageNumber reqPage;
    logic [PageOffsetWidth-1:0] reqOffset;
    MemoryAccessType reqType;

    logic lookupHit;
    TlbEntry lookupEntry;
    logic hitReg;
    TlbEntry entryReg;

    logic permitted;
    logic needWalk;
    logic walkEnable;
    logic walkDone;
    logic tlbWriteEnable;
    VirtualPageNumber tlbWriteKey;
    TlbEntry tlbWriteValue;

    assign reqReady = (state == StateIdle) && !respValid;

    always_comb begin
        case (reqType)
            AccessLoad: permitted = entryReg.flags.read;
            AccessStore: permitted = entryReg.flags.write;
            AccessInstruction: permitted = entryReg.flags.execute;
            default: permitted = 1'b0;
        endcase
        // A store to a clean writable page walks again to set dirty
        needWalk = !hitReg || (reqType == AccessStore && !entryReg.fault &&
                               entryReg.flags.write && !entryReg.flags.dirty);
    end

    assign walkEnable = (state == StateLookup) && lookupStage && needWalk;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= StateIdle;
            lookupStage <= 1'b0;
            respValid <= 1'b0;
        end else begin
            case (state)
                StateIdle: begin
                    if (respValid && respReady) begin
                        respValid <= 1'b0;
                    end
                    if (reqValid && reqReady) begin
                        state <= StateLookup;
                        lookupStage <= 1'b0;
                    end
                end
                StateLookup: begin
                    lookupStage <= !lookupStage;
                    if (lookupStage) begin
                        if (needWalk) begin
                            state <= StateWalk;
                        end else begin
                            state <= StateIdle;
                            respValid <= 1'b1;
                        end
                    end
                end
                StateWalk: if (walkDone) state <= StateLookup;
                default: state <= StateIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reqValid && reqReady) begin
            reqPage <= reqAddr[31 -: VpnWidth];
            reqOffset <= reqAddr[PageOffsetWidth-1:0];
            reqType <= reqAccessType;
        end
        hitReg <= lookupHit;
        entryReg <= lookupEntry;
        if ((state == StateLookup) && lookupStage && !needWalk) begin
            respAddr <= {entryReg.pageNumber, reqOffset};
            respFault <= entryReg.fault || !permitted;
        end
    end

    Tlb tlb (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .lookupPage(reqPage),
        .lookupHit(lookupHit),
        .lookupEntry(lookupEntry),
        .writeEnable(tlbWriteEnable),
        .writeKey(tlbWriteKey),
        .writeValue(tlbWriteValue)
    );

    TlbReplacer replacer (
        .clk(clk),
        .rst(rst),
        .enable(walkEnable),
        .missPage(reqPage),
        .missAccessType(reqType),
        .satpPpn(satpPpn),
        .done(walkDone),
        .tlbWriteEnable(tlbWriteEnable),
        .tlbWriteKey(tlbWriteKey),
        .tlbWriteValue(tlbWriteValue),
        .memAddr(memAddr),
        .memReadEnable(memReadEnable),
        .memWriteEnable(memWriteEnable),
        .memWriteValue(memWriteValue),
        .memReadDone(memReadDone),
        .memWriteDone(memWriteDone),
        .memReadValue(memReadValue)
    );

endmodule

//--- testbench/PageTableMemory.sv
module PageTableMemory (
    input  logic clk,
    input  logic rst,
    input  logic [29:0] addr,
    input  logic readEnable,
    input  logic writeEnable,
    input  logic [127:0] writeValue,
    output logic readDone,
    output logic writeDone,
    output logic [127:0] readValue,
    output int readCount,
    output int writeCount
);
    timeunit 1ns;
    timeprecision 1ns;

    // Sparse line store, missing lines read as zero
    logic [127:0] lines [bit [29:0]];

    integer latencySeed;
    int draw;
    logic [1:0] delay;
    logic active;

    initial begin
        latencySeed = 32'h8927c799;
        readDone = 1'b0;
        writeDone = 1'b0;
        readValue = '0;
        active = 1'b0;
        delay = 2'd0;
    end

    // Random latency of 0 to 3 extra cycles, done is a one-cycle pulse
    always @(posedge clk) begin
        readDone <= 1'b0;
        writeDone <= 1'b0;
        if (rst) begin
            active <= 1'b0;
            readCount <= 0;
            writeCount <= 0;
        end else if ((readEnable || writeEnable) && !readDone && !writeDone) begin
            if (!active) begin
                draw = $random(latencySeed);
                delay <= draw[1:0];
                active <= 1'b1;
            end else if (delay != 2'd0) begin
                delay <= delay - 2'd1;
            end else begin
                active <= 1'b0;
                if (readEnable) begin
                    readValue <= lines.exists(addr) ? lines[addr] : '0;
                    readDone <= 1'b1;
                    readCount <= readCount + 1;
                end else begin
                    lines[addr] = writeValue;
                    writeDone <= 1'b1;
                    writeCount <= writeCount + 1;
                end
            end
        end
    end

endmodule

//--- testbench/Mmu_assertions.sv
module MmuAssertions (
    input logic clk,
    input logic rst,
    input logic reqValid,
    input logic reqReady,
    input logic respValid,
    input logic respReady,
    input logic [33:0] respAddr,
    input logic respFault,
    input logic [29:0] memAddr,
    input logic memReadEnable,
    input logic memWriteEnable,
    input logic [127:0] memWriteValue,
    input logic memReadDone,
    input logic memWriteDone
);
    timeunit 1ns;
    timeprecision 1ns;

    // Stalled response keeps its data
    respHeld: assert property (@(posedge clk) disable iff (rst)
        respValid && !respReady |=> respValid && $stable(respAddr) && $stable(respFault))
        else $error("response changed while respReady was low");

    // Single memory port, one enable held with its address until the done pulse
    memRequestHeld: assert property (@(posedge clk) disable iff (rst)
        (memReadEnable || memWriteEnable) && !memReadDone && !memWriteDone
        |=> (memReadEnable != memWriteEnable) && $stable(memReadEnable)
            && $stable(memWriteEnable) && $stable(memAddr) && $stable(memWriteValue))
        else $error("memory request changed before its done pulse");

    // One request in flight, ready stays low until its response is taken
    noAcceptWhilePending: assert property (@(posedge clk) disable iff (rst)
        (reqValid && reqReady) || (!reqReady && !(respValid && respReady)) |=> !reqReady)
        else $error("reqReady rose before the pending response was accepted");

endmodule

//--- testbench/MmuTb.sv
module MmuTb;
    timeunit 1ns;
    timeprecision 1ns;

    import MmuTypes::*;

    localparam int NumRequests = 300;
    localparam int CycleLimit = NumRequests * 80;
    localparam int NumMappings = 24;
    localparam logic [21:0] RootPpn = 22'h000100;

    logic clk;
    logic rst;
    logic reqValid;
    logic reqReady;
    logic [31:0] reqAddr;
    MemoryAccessType reqAccessType;
    logic respValid;
    logic respReady;
    logic [33:0] respAddr;
    logic respFault;
    logic [21:0] satpPpn;
    logic flush;
    logic [29:0] memAddr;
    logic memReadEnable;
    logic memWriteEnable;
    logic [127:0] memWriteValue;
    logic memReadDone;
    logic memWriteDone;
    logic [127:0] memReadValue;
    int readCount;
    int writeCount;

    integer seed;
    int cycleCount;
    int errorCount;
    int checkCount;
    int walkCount;
    int faultCount;
    int flushCount;

    // Reference copy of the page tables
    logic [127:0] modelMem [bit [29:0]];
    logic [9:0] mapVpn1 [NumMappings];
    logic mapPointer [NumMappings];
    logic [9:0] lastVpn1;
    logic [9:0] lastVpn0;

    // Expected TLB contents, flags are {dirty, execute, write, read}
    logic tlbValid [16];
    logic [15:0] tlbTag [16];
    logic tlbFault [16];
    logic [21:0] tlbPpn [16];
    logic [3:0] tlbFlags [16];

    Mmu DUT (.*);

    PageTableMemory memory (
        .clk(clk),
        .rst(rst),
        .addr(memAddr),
        .readEnable(memReadEnable),
        .writeEnable(memWriteEnable),
        .writeValue(memWriteValue),
        .readDone(memReadDone),
        .writeDone(memWriteDone),
        .readValue(memReadValue),
        .readCount(readCount),
        .writeCount(writeCount)
    );

    bind Mmu MmuAssertions assertions (
        .clk(clk),
        .rst(rst),
        .reqValid(reqValid),
        .reqReady(reqReady),
        .respValid(respValid),
        .respReady(respReady),
        .respAddr(respAddr),
        .respFault(respFault),
        .memAddr(memAddr),
        .memReadEnable(memReadEnable),
        .memWriteEnable(memWriteEnable),
        .memWriteValue(memWriteValue),
        .memReadDone(memReadDone),
        .memWriteDone(memWriteDone)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < CycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout after %0d cycles, the DUT stopped responding", cycleCount);
        $display("TEST FAILED");
        $finish;
    end

    function automatic logic [127:0] readModel(logic [29:0] lineAddr);
        return modelMem.exists(lineAddr) ? modelMem[lineAddr] : '0;
    endfunction

    // Same line goes into the model and the memory
    task automatic putEntry(input logic [29:0] lineAddr, input logic [1:0] index,
                            input logic [31:0] pte);
        logic [127:0] line;
        line = readModel(lineAddr);
        line[32*index +: 32] = pte;
        modelMem[lineAddr] = line;
        memory.lines[lineAddr] = line;
    endtask

    // Leaf with R or X set and never W without R
    function automatic logic [31:0] randomLeaf();
        int r;
        int p;
        logic rd;
        r = $random(seed);
        p = $random(seed);
        rd = r[0] || r[1] || !r[2];
        return {p[21:0], 2'b00, r[5], r[4], 1'b0, r[3], r[2], r[1], rd, 1'b1};
    endfunction

    function automatic logic [31:0] randomLevel0();
        int r;
        int p;
        r = $random(seed);
        p = $random(seed);
        case (r[10:8])
            3'd0: return {p[31:1], 1'b0};
            3'd1: return {p[31:4], p[3], 3'b011 ^ 3'b010 ^ 3'b100};
            3'd2: return {p[21:0], 10'b00_0000_0001};
            default: return randomLeaf();
        endcase
    endfunction

    task automatic buildTables();
        logic [31:0] pte;
        logic [21:0] tablePpn;
        int r;
        for (int i = 0; i < NumMappings; i++) begin
            mapVpn1[i] = 10'((i * 37 + 5) % 1024);
            tablePpn = 22'(32'h200 + i);
            mapPointer[i] = (i % 6 == 1) || (i % 6 == 2);
            r = $random(seed);
            case (i % 6)
                1, 2: begin
                    pte = {tablePpn, 10'b00_0000_0001};
                    for (int j = 0; j < 8; j++) begin
                        putEntry({tablePpn, 8'(j / 4)}, 2'(j % 4), randomLevel0());
                    end
                end
                3: pte = {r[31:1], 1'b0};
                // Write without read
                4: pte = {r[31:4], r[3], 3'b101};
                default: pte = randomLeaf();
            endcase
            putEntry({RootPpn, mapVpn1[i][9:2]}, mapVpn1[i][1:0], pte);
        end
    endtask

    // Sv32 walk with A and D updates, fills the expected TLB
    task automatic modelWalk(input logic [9:0] vpn1, input logic [9:0] vpn0,
                             input logic [1:0] accType, output int reads);
        logic [29:0] lineAddr;
        logic [127:0] line;
        logic [31:0] pte;
        logic [21:0] ppn;
        logic fault;
        logic [3:0] slot;
        lineAddr = {RootPpn, vpn1[9:2]};
        line = readModel(lineAddr);
        pte = line[32*vpn1[1:0] +: 32];
        reads = 1;
        fault = 1'b0;
        ppn = '0;
        if (!pte[0] || (pte[2] && !pte[1])) begin
            fault = 1'b1;
        end else if (pte[1] || pte[3]) begin
            pte[6] = 1'b1;
            if (accType == 2'd2 && pte[2]) pte[7] = 1'b1;
            line[32*vpn1[1:0] +: 32] = pte;
            modelMem[lineAddr] = line;
            ppn = {pte[31:20], vpn0};
        end else begin
            reads = 2;
            lineAddr = {pte[31:10], vpn0[9:2]};
            line = readModel(lineAddr);
            pte = line[32*vpn0[1:0] +: 32];
            if (!pte[0] || (pte[2] && !pte[1]) || !(pte[1] || pte[3])) begin
                fault = 1'b1;
            end else begin
                pte[6] = 1'b1;
                if (accType == 2'd2 && pte[2]) pte[7] = 1'b1;
                line[32*vpn0[1:0] +: 32] = pte;
                modelMem[lineAddr] = line;
                ppn = pte[31:10];
            end
        end
        slot = vpn0[3:0];
        tlbValid[slot] = 1'b1;
        tlbTag[slot] = {vpn1, vpn0[9:4]};
        tlbFault[slot] = fault;
        tlbPpn[slot] = fault ? 22'd0 : ppn;
        tlbFlags[slot] = fault ? 4'd0 : {pte[7], pte[3], pte[2], pte[1]};
    endtask

    task automatic runRequest(input int n);
        int r;
        int idx;
        int expectReads;
        int readsBefore;
        logic [9:0] vpn1;
        logic [9:0] vpn0;
        logic [11:0] offset;
        logic [1:0] accType;
        logic [3:0] slot;
        logic hit;
        logic expectWalk;
        logic expectFault;
        logic permitted;
        logic [33:0] expectAddr;
        logic held;
        logic accepted;
        logic [33:0] heldAddr;
        logic heldFault;
        r = $random(seed);
        if (n > 0 && r[3:0] < 4'd5) begin
            vpn1 = lastVpn1;
            vpn0 = lastVpn0;
        end else if (r[7:4] == 4'd0) begin
            // Outside every mapping
            vpn1 = 10'd990 + {5'd0, r[12:8]};
            vpn0 = r[22:13];
        end else begin
            idx = r[15:8] % NumMappings;
            vpn1 = mapVpn1[idx];
            if (mapPointer[idx]) begin
                vpn0 = (r[18:16] == 3'd0) ? {6'd0, 1'b1, r[21:19]} : {7'd0, r[21:19]};
            end else begin
                vpn0 = r[27:18];
            end
        end
        lastVpn1 = vpn1;
        lastVpn0 = vpn0;
        r = $random(seed);
        offset = r[11:0];
        accType = (r[13:12] == 2'd3) ? 2'd1 : r[13:12];

        if (r[20:16] == 5'd0) begin
            flush <= 1'b1;
            @(posedge clk);
            flush <= 1'b0;
            for (int i = 0; i < 16; i++) tlbValid[i] = 1'b0;
            flushCount++;
        end

        slot = vpn0[3:0];
        hit = tlbValid[slot] && tlbTag[slot] == {vpn1, vpn0[9:4]};
        expectWalk = !hit || (accType == 2'd2 && !tlbFault[slot] && tlbFlags[slot][1]
                              && !tlbFlags[slot][3]);
        expectReads = 0;
        if (expectWalk) begin
            modelWalk(vpn1, vpn0, accType, expectReads);
            walkCount++;
        end
        case (accType)
            2'd0: permitted = tlbFlags[slot][2];
            2'd2: permitted = tlbFlags[slot][1];
            default: permitted = tlbFlags[slot][0];
        endcase
        expectFault = tlbFault[slot] || !permitted;
        expectAddr = {tlbPpn[slot], offset};
        if (expectFault) faultCount++;

        readsBefore = readCount;
        reqValid <= 1'b1;
        reqAddr <= {vpn1, vpn0, offset};
        reqAccessType <= MemoryAccessType'(accType);
        @(posedge clk);
        while (!reqReady) @(posedge clk);
        reqValid <= 1'b0;

        held = 1'b0;
        accepted = 1'b0;
        heldAddr = '0;
        heldFault = 1'b0;
        while (!accepted) begin
            @(posedge clk);
            if (respValid) begin
                if (held) begin
                    assert (respAddr == heldAddr && respFault == heldFault) else begin
                        $display("Response %0d changed while stalled", n);
                        errorCount++;
                    end
                end
                held = 1'b1;
                heldAddr = respAddr;
                heldFault = respFault;
                accepted = respReady;
            end
            r = $random(seed);
            respReady <= (r[1:0] != 2'd0);
        end

        checkCount += 3;
        assert (respFault == expectFault) else begin
            $display("MISMATCH respFault request %0d: got %h expected %h",
                     n, respFault, expectFault);
            errorCount++;
        end
        if (!expectFault) begin
            assert (respAddr == expectAddr) else begin
                $display("MISMATCH respAddr request %0d: got %h expected %h",
                         n, respAddr, expectAddr);
                errorCount++;
            end
        end
        assert (readCount - readsBefore == expectReads) else begin
            $display("MISMATCH readCount request %0d: got %h expected %h",
                     n, readCount - readsBefore, expectReads);
            errorCount++;
        end
    endtask

    task automatic compareMemory(output int compared);
        compared = 0;
        foreach (modelMem[lineAddr]) begin
            compared++;
            checkCount++;
            assert (memory.lines.exists(lineAddr) && memory.lines[lineAddr] == modelMem[lineAddr])
            else begin
                $display("MISMATCH memory line %h: got %h expected %h", lineAddr,
                         memory.lines[lineAddr], modelMem[lineAddr]);
                errorCount++;
            end
        end
    endtask

    initial begin
        int compared;
        int firstErrors;
        seed = 32'h8927c799;
        errorCount = 0;
        checkCount = 0;
        walkCount = 0;
        faultCount = 0;
        flushCount = 0;
        rst = 1'b1;
        reqValid = 1'b0;
        reqAddr = '0;
        reqAccessType = AccessLoad;
        respReady = 1'b0;
        flush = 1'b0;
        satpPpn = RootPpn;
        for (int i = 0; i < 16; i++) tlbValid[i] = 1'b0;
        buildTables();

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        for (int n = 0; n < NumRequests; n++) runRequest(n);
        firstErrors = errorCount;
        $display("Test 1 random requests: %0d sent, %0d walks, %0d flushes, %0d faults, %0d errors",
                 NumRequests, walkCount, flushCount, faultCount, firstErrors);

        compareMemory(compared);
        $display("Test 2 write-back: %0d lines compared, %0d writes seen, %0d errors",
                 compared, writeCount, errorCount - firstErrors);

        $display("Checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- sources.f
src/MmuTypes.sv
src/Tlb.sv
src/TlbReplacer.sv
src/Mmu.sv
testbench/PageTableMemory.sv
testbench/Mmu_assertions.sv
testbench/MmuTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= MmuTb
BUILD_DIR ?= obj_dir
FILE_LIST ?= sources.f
VFLAGS ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR)
